// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define XLEN      64
`define REG_COUNT 32
`define RESET_PC  64'h0000_0000_8000_0000 // first fetch address

`endif

// ==== rtl/corePkg.sv ====
`default_nettype none

`include "core_settings.svh"

package corePkg;

    typedef logic [`XLEN-1:0] wordT;
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassA,
        aluPassB,
        aluNone
    } aluOpE;

    typedef enum logic {
        srcARs1,
        srcAPc
    } srcAE;

    typedef enum logic {
        srcBRs2,
        srcBImm
    } srcBE;

    typedef enum logic [1:0] {
        flowSeq,
        flowJal,
        flowJalr,
        flowBranch
    } flowE;

    typedef struct packed {
        aluOpE      aluOp;
        srcAE       srcA;
        srcBE       srcB;
        logic       wordOp;       // truncate to 32, sign extend
        logic       shiftWord32;  // rs1 narrowed before srl/sra
        logic       writeRd;
        flowE       flow;
        logic [2:0] branchFunct3;
        wordT       imm;
    } decodeT;

    typedef struct packed {
        decodeT dec;
        wordT   pc;
        regIdxT rd;
        wordT   rs1Val;
        wordT   rs2Val;
    } issueT;

    typedef struct packed {
        logic   valid;
        logic   writeRd;
        regIdxT rd;
        wordT   data;
        wordT   nextPc;
    } retireT;

endpackage

`default_nettype wire

// ==== rtl/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module instDecoder (
    input  wire [31:0]      inst,
    output corePkg::decodeT dec
);

    logic [6:0]    opCode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    corePkg::wordT immI;
    corePkg::wordT immU;
    corePkg::wordT immJ;
    corePkg::wordT immB;

    assign opCode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign immU = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immB = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        dec.aluOp        = corePkg::aluNone;
        dec.srcA         = corePkg::srcARs1;
        dec.srcB         = corePkg::srcBRs2;
        dec.wordOp       = 1'b0;
        dec.shiftWord32  = 1'b0;
        dec.writeRd      = 1'b0;
        dec.flow         = corePkg::flowSeq;
        dec.branchFunct3 = funct3;
        dec.imm          = '0;
        case (opCode)
            7'b0110011: begin // R type
                dec.writeRd = 1'b1;
                case (funct7)
                    7'h00: begin
                        case (funct3)
                            3'b000: dec.aluOp = corePkg::aluAdd;
                            3'b001: dec.aluOp = corePkg::aluSll;
                            3'b010: dec.aluOp = corePkg::aluSlt;
                            3'b011: dec.aluOp = corePkg::aluSltu;
                            3'b100: dec.aluOp = corePkg::aluXor;
                            3'b101: dec.aluOp = corePkg::aluSrl;
                            3'b110: dec.aluOp = corePkg::aluOr;
                            3'b111: dec.aluOp = corePkg::aluAnd;
                            default: ;
                        endcase
                    end
                    7'h20: begin
                        case (funct3)
                            3'b000: dec.aluOp = corePkg::aluSub;
                            3'b101: dec.aluOp = corePkg::aluSra;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
            7'b0010011: begin // I type
                dec.srcB    = corePkg::srcBImm;
                dec.imm     = immI;
                dec.writeRd = 1'b1;
                case (funct3)
                    3'b000: dec.aluOp = corePkg::aluAdd;
                    3'b010: dec.aluOp = corePkg::aluSlt;
                    3'b011: dec.aluOp = corePkg::aluSltu;
                    3'b100: dec.aluOp = corePkg::aluXor;
                    3'b110: dec.aluOp = corePkg::aluOr;
                    3'b111: dec.aluOp = corePkg::aluAnd;
                    3'b001: begin
                        if (funct7[6:1] == 6'h00) dec.aluOp = corePkg::aluSll;
                    end
                    3'b101: begin
                        case (funct7[6:1]) // shamt bit 5 lives in funct7
                            6'h00: dec.aluOp = corePkg::aluSrl;
                            6'h10: dec.aluOp = corePkg::aluSra;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
            7'b0111011: begin // R type, 32 bit
                dec.wordOp  = 1'b1;
                dec.writeRd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.aluOp = corePkg::aluAdd;
                    {7'h20, 3'b000}: dec.aluOp = corePkg::aluSub;
                    {7'h00, 3'b001}: dec.aluOp = corePkg::aluSll;
                    {7'h00, 3'b101}: begin
                        dec.aluOp       = corePkg::aluSrl;
                        dec.shiftWord32 = 1'b1;
                    end
                    {7'h20, 3'b101}: begin
                        dec.aluOp       = corePkg::aluSra;
                        dec.shiftWord32 = 1'b1;
                    end
                    default: ;
                endcase
            end
            7'b0011011: begin // I type, 32 bit
                dec.srcB    = corePkg::srcBImm;
                dec.imm     = immI;
                dec.wordOp  = 1'b1;
                dec.writeRd = 1'b1;
                case (funct3)
                    3'b000: dec.aluOp = corePkg::aluAdd;
                    3'b001: begin
                        if (funct7 == 7'h00) dec.aluOp = corePkg::aluSll;
                    end
                    3'b101: begin
                        dec.shiftWord32 = 1'b1;
                        case (funct7)
                            7'h00: dec.aluOp = corePkg::aluSrl;
                            7'h20: dec.aluOp = corePkg::aluSra;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
            7'b0110111: begin // lui
                dec.srcB    = corePkg::srcBImm;
                dec.imm     = immU;
                dec.writeRd = 1'b1;
                dec.aluOp   = corePkg::aluPassB;
            end
            7'b0010111: begin // auipc
                dec.srcA    = corePkg::srcAPc;
                dec.srcB    = corePkg::srcBImm;
                dec.imm     = immU;
                dec.writeRd = 1'b1;
                dec.aluOp   = corePkg::aluAdd;
            end
            7'b1101111: begin // jal
                dec.imm     = immJ;
                dec.writeRd = 1'b1;
                dec.flow    = corePkg::flowJal;
            end
            7'b1100111: begin // jalr
                if (funct3 == 3'b000) begin
                    dec.imm     = immI;
                    dec.writeRd = 1'b1;
                    dec.flow    = corePkg::flowJalr;
                end
            end
            7'b1100011: begin // branches
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    dec.imm  = immB;
                    dec.flow = corePkg::flowBranch;
                end
            end
            default: ;
        endcase
        // no alu op and no jump means nothing to write back
        if (dec.flow == corePkg::flowSeq && dec.aluOp == corePkg::aluNone) dec.writeRd = 1'b0;
    end

endmodule

`default_nettype wire

// ==== rtl/operandFetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module operandFetch (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire                  instValid,
    input  wire [31:0]           inst,
    input  wire corePkg::wordT   pc,
    input  wire corePkg::decodeT dec,
    input  wire corePkg::retireT fwd,
    input  wire corePkg::retireT wb,
    output corePkg::issueT       issue,
    output logic                 issueValid
);

    corePkg::wordT   regFile [`REG_COUNT];
    corePkg::regIdxT rs1Idx;
    corePkg::regIdxT rs2Idx;
    corePkg::regIdxT rdIdx;
    corePkg::wordT   rs1Val;
    corePkg::wordT   rs2Val;

    assign rs1Idx = inst[19:15];
    assign rs2Idx = inst[24:20];
    assign rdIdx  = inst[11:7];

    // alu result wins over the retiring one, which is older
    function automatic corePkg::wordT resolve(
        input corePkg::regIdxT idx,
        input corePkg::wordT   rfVal,
        input corePkg::retireT aluRes,
        input corePkg::retireT wbRes
    );
        if (idx == '0) return '0;
        if (aluRes.valid && aluRes.writeRd && aluRes.rd == idx) return aluRes.data;
        if (wbRes.valid && wbRes.writeRd && wbRes.rd == idx) return wbRes.data;
        return rfVal;
    endfunction

    assign rs1Val = resolve(rs1Idx, regFile[rs1Idx], fwd, wb);
    assign rs2Val = resolve(rs2Idx, regFile[rs2Idx], fwd, wb);

    always_ff @(posedge clk) begin
        if (wb.valid && wb.writeRd) regFile[wb.rd] <= wb.data; // x0 already filtered
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= instValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            issue.dec    <= dec;
            issue.pc     <= pc;
            issue.rd     <= rdIdx;
            issue.rs1Val <= rs1Val;
            issue.rs2Val <= rs2Val;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module aluUnit (
    input  wire corePkg::issueT issue,
    input  wire                 issueValid,
    output corePkg::retireT     result
);

    corePkg::wordT opA;
    corePkg::wordT opB;
    corePkg::wordT aluOut;
    corePkg::wordT pcPlus4;
    corePkg::wordT pcTarget;
    corePkg::wordT jalrTarget;
    logic [5:0]    shamt;
    logic          taken;

    always_comb begin
        opA = (issue.dec.srcA == corePkg::srcAPc) ? issue.pc : issue.rs1Val;
        if (issue.dec.shiftWord32) begin
            if (issue.dec.aluOp == corePkg::aluSra) begin
                opA = {{(`XLEN-32){issue.rs1Val[31]}}, issue.rs1Val[31:0]};
            end else begin
                opA = {{(`XLEN-32){1'b0}}, issue.rs1Val[31:0]};
            end
        end
    end

    assign opB   = (issue.dec.srcB == corePkg::srcBImm) ? issue.dec.imm : issue.rs2Val;
    assign shamt = issue.dec.wordOp ? {1'b0, opB[4:0]} : opB[5:0]; // W forms shift by 5 bits

    always_comb begin
        case (issue.dec.aluOp)
            corePkg::aluAdd:   aluOut = opA + opB;
            corePkg::aluSub:   aluOut = opA - opB;
            corePkg::aluSll:   aluOut = opA << shamt;
            corePkg::aluSlt:   aluOut = corePkg::wordT'($signed(opA) < $signed(opB));
            corePkg::aluSltu:  aluOut = corePkg::wordT'(opA < opB);
            corePkg::aluXor:   aluOut = opA ^ opB;
            corePkg::aluSrl:   aluOut = opA >> shamt;
            corePkg::aluSra:   aluOut = corePkg::wordT'($signed(opA) >>> shamt);
            corePkg::aluOr:    aluOut = opA | opB;
            corePkg::aluAnd:   aluOut = opA & opB;
            corePkg::aluPassA: aluOut = opA;
            corePkg::aluPassB: aluOut = opB;
            default:           aluOut = '0;
        endcase
    end

    always_comb begin
        case (issue.dec.branchFunct3)
            3'b000:  taken = issue.rs1Val == issue.rs2Val;
            3'b001:  taken = issue.rs1Val != issue.rs2Val;
            3'b100:  taken = $signed(issue.rs1Val) < $signed(issue.rs2Val);
            3'b101:  taken = $signed(issue.rs1Val) >= $signed(issue.rs2Val);
            3'b110:  taken = issue.rs1Val < issue.rs2Val;
            3'b111:  taken = issue.rs1Val >= issue.rs2Val;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4    = issue.pc + corePkg::wordT'(4);
    assign pcTarget   = issue.pc + issue.dec.imm;
    assign jalrTarget = issue.rs1Val + issue.dec.imm;

    always_comb begin
        result.valid   = issueValid;
        result.writeRd = issueValid && issue.dec.writeRd;
        result.rd      = issue.rd;
        result.data    = issue.dec.wordOp ? {{(`XLEN-32){aluOut[31]}}, aluOut[31:0]} : aluOut;
        result.nextPc  = pcPlus4;
        case (issue.dec.flow)
            corePkg::flowJal: begin
                result.data   = pcPlus4; // link value
                result.nextPc = pcTarget;
            end
            corePkg::flowJalr: begin
                result.data   = pcPlus4;
                result.nextPc = {jalrTarget[`XLEN-1:1], 1'b0};
            end
            corePkg::flowBranch: begin
                if (taken) result.nextPc = pcTarget;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/retireStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module retireStage (
    input  wire                  clk,
    input  wire                  arstN,
    input  wire corePkg::retireT result,
    output corePkg::retireT      retire
);

    logic            validQ;
    logic            writeRdQ;
    corePkg::regIdxT rdQ;
    corePkg::wordT   dataQ;
    corePkg::wordT   nextPcQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ   <= 1'b0;
            writeRdQ <= 1'b0;
            nextPcQ  <= `RESET_PC;
        end else begin
            validQ   <= result.valid;
            writeRdQ <= result.valid && result.writeRd && (result.rd != '0); // drop x0 writes
            if (result.valid) nextPcQ <= result.nextPc; // hold pc across idle cycles
        end
    end

    always_ff @(posedge clk) begin
        if (result.valid) begin
            rdQ   <= result.rd;
            dataQ <= result.data;
        end
    end

    assign retire = '{valid: validQ, writeRd: writeRdQ, rd: rdQ, data: dataQ, nextPc: nextPcQ};

endmodule

`default_nettype wire

// ==== rtl/execCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  wire                clk,
    input  wire                arstN,
    input  wire                instValid,
    input  wire [31:0]         inst,
    input  wire corePkg::wordT pc,
    output corePkg::retireT    retire
);

    corePkg::decodeT dec;
    corePkg::issueT  issue;
    logic            issueValid;
    corePkg::retireT result;

    instDecoder uDecoder (
        .inst (inst),
        .dec  (dec)
    );

    operandFetch uFetch (
        .clk        (clk),
        .arstN      (arstN),
        .instValid  (instValid),
        .inst       (inst),
        .pc         (pc),
        .dec        (dec),
        .fwd        (result),  // instruction still in the alu
        .wb         (retire),  // write port back into the register file
        .issue      (issue),
        .issueValid (issueValid)
    );

    aluUnit uAlu (
        .issue      (issue),
        .issueValid (issueValid),
        .result     (result)
    );

    retireStage uRetire (
        .clk    (clk),
        .arstN  (arstN),
        .result (result),
        .retire (retire)
    );

endmodule

`default_nettype wire

// ==== bench/execCore_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execCore_checker (
    input wire                  clk,
    input wire                  arstN,
    input wire                  instValid,
    input wire [31:0]           inst,
    input wire corePkg::wordT   pc,
    input wire corePkg::retireT retire
);

    typedef struct packed {
        logic          valid;
        logic [31:0]   inst;
        logic          writeRd;
        logic [4:0]    rd;
        corePkg::wordT data;
        corePkg::wordT nextPc;
    } expectT;

    corePkg::wordT shadow [`REG_COUNT]; // architectural state as the ISA defines it
    corePkg::wordT rs1Val;
    corePkg::wordT rs2Val;
    expectT        expNow;
    expectT        expA;                // instruction in the issue register
    expectT        expB;                // instruction in the retire register
    logic          issuedQ;
    int            errCount = 0;

    function automatic corePkg::wordT sext32(input corePkg::wordT v);
        return {{(`XLEN-32){v[31]}}, v[31:0]};
    endfunction

    function automatic corePkg::wordT arith(input logic [2:0] f3, input logic alt,
                                            input corePkg::wordT a, input corePkg::wordT b,
                                            input logic word);
        logic [5:0] sh;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return corePkg::wordT'($signed(a) < $signed(b));
            3'd3: return corePkg::wordT'(a < b);
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return corePkg::wordT'($signed(a) >>> sh);
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic expectT model(input logic [31:0] i, input corePkg::wordT p,
                                     input corePkg::wordT a, input corePkg::wordT b);
        expectT        e;
        corePkg::wordT immI;
        corePkg::wordT immU;
        corePkg::wordT immJ;
        corePkg::wordT immB;
        corePkg::wordT nA;
        logic          taken;
        immI = {{(`XLEN-12){i[31]}}, i[31:20]};
        immU = {{(`XLEN-32){i[31]}}, i[31:12], 12'b0};
        immJ = {{(`XLEN-21){i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        immB = {{(`XLEN-13){i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        nA   = i[30] ? sext32(a) : {{(`XLEN-32){1'b0}}, a[31:0]}; // srlw and sraw source
        e = '{valid: 1'b1, inst: i, writeRd: 1'b1, rd: i[11:7], data: '0, nextPc: p + 64'd4};
        case (i[6:0])
            7'h33: e.data = arith(i[14:12], i[30], a, b, 1'b0);
            7'h13: e.data = arith(i[14:12], i[30] && i[14:12] == 3'd5, a, immI, 1'b0);
            7'h3b: e.data = sext32(arith(i[14:12], i[30], (i[14:12] == 3'd5) ? nA : a, b, 1'b1));
            7'h1b: e.data = sext32(arith(i[14:12], i[30] && i[14:12] == 3'd5,
                                         (i[14:12] == 3'd5) ? nA : a, immI, 1'b1));
            7'h37: e.data = immU;
            7'h17: e.data = p + immU;
            7'h6f: begin
                e.data   = p + 64'd4;
                e.nextPc = p + immJ;
            end
            7'h67: begin
                e.data   = p + 64'd4;
                e.nextPc = (a + immI) & ~corePkg::wordT'(1);
            end
            7'h63: begin
                case (i[14:12])
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                e.writeRd = 1'b0;
                if (taken) e.nextPc = p + immB;
            end
            default: e.writeRd = 1'b0; // not implemented here
        endcase
        if (e.rd == 5'd0) e.writeRd = 1'b0;
        return e;
    endfunction

    assign rs1Val = (inst[19:15] == 5'd0) ? '0 : shadow[inst[19:15]];
    assign rs2Val = (inst[24:20] == 5'd0) ? '0 : shadow[inst[24:20]];
    assign expNow = model(inst, pc, rs1Val, rs2Val);

    always_ff @(posedge clk) begin
        if (instValid && expNow.writeRd) shadow[expNow.rd] <= expNow.data;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issuedQ <= 1'b0;
            expA    <= '0;
            expB    <= '0;
        end else begin
            if (instValid) issuedQ <= 1'b1;
            expA <= instValid ? expNow : '0;
            expB <= expA;
        end
    end

    aResetState: assert property (@(posedge clk) disable iff (!arstN)
        !issuedQ |-> !retire.valid && retire.nextPc == `RESET_PC)
        else begin
            $error("Error reset state: expected valid 0 nextPc %h actual valid %b nextPc %h",
                   `RESET_PC, $sampled(retire.valid), $sampled(retire.nextPc));
            errCount++;
        end

    aValidTiming: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid == expB.valid)
        else begin
            $error("Error retire valid timing: expected %b actual %b",
                   $sampled(expB.valid), $sampled(retire.valid));
            errCount++;
        end

    aWriteEnable: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid |-> retire.writeRd == expB.writeRd && (!expB.writeRd || retire.rd == expB.rd))
        else begin
            $error("Error write enable: inst %h expected writeRd %b rd %0d actual writeRd %b rd %0d",
                   $sampled(expB.inst), $sampled(expB.writeRd), $sampled(expB.rd),
                   $sampled(retire.writeRd), $sampled(retire.rd));
            errCount++;
        end

    aData: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid && expB.writeRd |-> retire.data == expB.data)
        else begin
            $error("Error retire data: inst %h expected %h actual %h",
                   $sampled(expB.inst), $sampled(expB.data), $sampled(retire.data));
            errCount++;
        end

    aNextPc: assert property (@(posedge clk) disable iff (!arstN)
        retire.valid |-> retire.nextPc == expB.nextPc)
        else begin
            $error("Error next pc: inst %h expected %h actual %h",
                   $sampled(expB.inst), $sampled(expB.nextPc), $sampled(retire.nextPc));
            errCount++;
        end

endmodule

`default_nettype wire

// ==== bench/execCore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module execCore_tb;

    logic            clk;
    logic            arstN;
    logic            instValid;
    logic [31:0]     inst;
    corePkg::wordT   pc;
    corePkg::retireT retire;

    execCore DUT (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .retire    (retire)
    );

    bind execCore execCore_checker uChecker (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        if (DUT.uChecker.errCount != 0) begin
            $display("** FAIL **");
            $fatal(1, "checker assertion failed");
        end
    end

    // legal encodings only, registers x0 to x8
    function automatic logic [31:0] randInst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  w3;
        logic [11:0] imm;
        logic        alt;
        rd  = 5'($urandom_range(8));
        rs1 = 5'($urandom_range(8));
        rs2 = 5'($urandom_range(8));
        f3  = 3'($urandom);
        imm = 12'($urandom);
        alt = 1'($urandom);
        w3  = f3[0] ? (f3[1] ? 3'd5 : 3'd1) : 3'd0; // add, sll or shift right
        if (f3 == 3'd1 || f3 == 3'd5) imm[11:6] = {1'b0, f3 == 3'd5 && alt, 4'b0};
        case ($urandom_range(9))
            0: return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, 7'h33};
            1: return {imm, rs1, f3, rd, 7'h13};
            2: return {1'b0, alt && w3 != 3'd1, 5'b0, rs2, rs1, w3, rd, 7'h3b};
            3: return {((w3 == 3'd0) ? imm[11:5] : {1'b0, alt && w3 == 3'd5, 5'b0}),
                       imm[4:0], rs1, w3, rd, 7'h1b};
            4: return {20'($urandom), rd, 7'h37};
            5: return {20'($urandom), rd, 7'h17};
            6: return {20'($urandom), rd, 7'h6f};
            7: return {imm, rs1, 3'd0, rd, 7'h67};
            8: return {imm[11:5], rs2, rs1, ((f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3),
                       imm[4:0], 7'h63};
            default: return {25'($urandom), 7'h03}; // load, not implemented
        endcase
    endfunction

    task automatic issueInst(input logic [31:0] word);
        instValid = 1'b1;
        inst      = word;
        pc        = pc + 64'd4;
        @(posedge clk);
        #1;
        instValid = 1'b0;
    endtask

    task automatic waitRetire();
        for (int t = 0; t < 20; t++) begin
            @(posedge clk);
            #1;
            if (retire.valid) return;
        end
        $display("** FAIL **");
        $fatal(1, "timeout: no retire pulse within 20 cycles");
    endtask

    initial begin
        int gap;
        void'($urandom(76));
        arstN     = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        pc        = `RESET_PC;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (2) @(posedge clk); // idle window for the reset state check
        #1;
        for (int r = 1; r <= 8; r++) issueInst({12'($urandom), 5'd0, 3'd0, 5'(r), 7'h13});
        waitRetire();
        for (int n = 0; n < 400; n++) begin
            issueInst(randInst());
            gap = $urandom_range(3);
            if (gap == 3) waitRetire(); // otherwise back to back
        end
        if (gap != 3) waitRetire(); // last retire not seen yet
        repeat (3) @(posedge clk);
        if (DUT.uChecker.errCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "checker reported %0d failures", DUT.uChecker.errCount);
        end
    end

endmodule

`default_nettype wire

// ==== execCore.f ====
+incdir+include
rtl/corePkg.sv
rtl/instDecoder.sv
rtl/operandFetch.sv
rtl/aluUnit.sv
rtl/retireStage.sv
rtl/execCore.sv
bench/execCore_checker.sv
bench/execCore_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -f execCore.f --top-module execCore_tb -o execCore_sim

# keep running past assertion errors so the testbench reports the result itself
out=$(./obj_dir/execCore_sim +verilator+error+limit+1000) || true
echo "$out"

echo "$out" | grep -qF '** PASS **'
